//--- sim.f
verilog/fetch_pkg.sv
verilog/fetch_regs.sv
verilog/ring_offsets.sv
verilog/fetch_fsm.sv
verilog/beat_router.sv
verilog/stream_fifo.sv
verilog/data_fetch.sv
sim/tb_checker.sv
sim/tb_data_fetch.sv

//--- Makefile
.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -Wno-fatal --top-module tb_data_fetch -f sim.f -Mdir obj_dir

run: compile
	./obj_dir/Vtb_data_fetch | tee sim.log
	@if grep -q "Finished with errors" sim.log; then echo "Simulation FAILED"; exit 1; fi
	@grep -q "Finished with no errors" sim.log || (echo "Simulation ended without a result"; exit 1)

clean:
	rm -rf obj_dir sim.log

//--- sim/tb_data_fetch.sv
// Testbench for data_fetch; memory answers bursts in request order, config is written once at start
`timescale 1ns/1ns

module tb_data_fetch;
   import fetch_pkg::*;

   localparam int NUM_ROWS   = 10;
   localparam int FRAME_SIZE = 1024;
   localparam int FD_RING    = 1536;
   localparam int MD_RING    = 384;
   // Beats per command, six cycles each at worst, plus setup
   localparam int TIMEOUT    = NUM_ROWS * (MD_BEATS + FRAME_SIZE / BUS_BYTES) * 6 + 500;
   // Indexed [phase * 2 + semiphase]
   localparam logic [3:0][63:0] FD_BASE = {64'h0000_0001_0003_0000, 64'h0000_0001_0002_0000,
                                           64'h0000_0001_0001_0000, 64'h0000_0001_0000_0000};
   localparam logic [1:0][63:0] MD_BASE = {64'h0000_0002_0000_1000, 64'h0000_0002_0000_0000};

   // Phase, stall percent on both output readies, per-phase command count
   typedef struct packed {
      logic       phase;
      logic [6:0] stall_pct;
      logic [2:0] row;
   } row_t;

   row_t rows [NUM_ROWS] = '{'{1'b0, 7'd0, 3'd0},  '{1'b0, 7'd0, 3'd1},  '{1'b0, 7'd25, 3'd2},
                             '{1'b0, 7'd50, 3'd3}, '{1'b1, 7'd0, 3'd0},  '{1'b0, 7'd70, 3'd4},
                             '{1'b1, 7'd30, 3'd1}, '{1'b0, 7'd10, 3'd5}, '{1'b1, 7'd60, 3'd2},
                             '{1'b1, 7'd40, 3'd3}};

   logic       clk;
   logic       resetn;
   cfg_wr_t    cfg;
   logic       cfg_err;
   logic       cmd_phase, cmd_valid, cmd_ready;
   logic [2:0] exp_row;
   rd_req_t    ar_req;
   logic       ar_valid;
   logic       ar_ready = 1'b0;
   beat_t      r_data   = '0;
   logic       r_valid  = 1'b0;
   logic       r_ready;
   beat_t      md_data;
   logic       md_valid;
   logic       md_ready = 1'b0;
   beat_t      fd_data;
   logic       fd_valid;
   logic       fd_ready = 1'b0;
   logic [6:0] stall_pct;
   int         mismatches;
   int         other_errs;
   logic       busy;
   int         cycles;
   // Accepted requests still to be answered
   rd_req_t    pend_q [$];
   logic [63:0] beat_addr;
   int          beats_left;

   data_fetch data_fetch_inst (.*);

   tb_checker #(.FD_BASE(FD_BASE), .MD_BASE(MD_BASE), .FRAME_SIZE(FRAME_SIZE),
                .FD_RING(FD_RING), .MD_RING(MD_RING)) checker_inst (.*);

   initial begin
      clk = 1'b0;
      forever #10 clk = ~clk;
   end

   //============================================================
   // Random readies and the read memory
   //============================================================
   always @(posedge clk) begin
      ar_ready <= ($urandom % 4) != 0;
      md_ready <= ($urandom % 100) >= stall_pct;
      fd_ready <= ($urandom % 100) >= stall_pct;
   end

   // Each data word is the byte address of its beat
   always @(posedge clk) begin
      rd_req_t cur;
      if (!resetn) begin
         r_valid <= 1'b0;
         beats_left = 0;
      end else begin
         if (ar_valid && ar_ready) begin
            pend_q.push_back(ar_req);
         end
         // Beat held until the DUT takes it
         if (!r_valid || r_ready) begin
            if (beats_left == 0 && pend_q.size() != 0) begin
               cur = pend_q.pop_front();
               beat_addr = cur.addr;
               beats_left = int'(cur.len) + 1;
            end
            if (beats_left != 0 && ($urandom % 8) != 0) begin
               r_valid <= 1'b1;
               r_data <= beat_addr;
               beat_addr = beat_addr + 64'(BUS_BYTES);
               beats_left--;
            end else begin
               r_valid <= 1'b0;
            end
         end
      end
   end

   task automatic write_reg(input int idx, input logic [31:0] data);
      @(posedge clk);
      cfg <= '{wr: 1'b1, idx: idx[REG_IDX_BITS-1:0], data: data};
      @(posedge clk);
      cfg <= '0;
   endtask

   task automatic send_cmd(input row_t r);
      @(posedge clk);
      cmd_phase <= r.phase;
      exp_row   <= r.row;
      stall_pct <= r.stall_pct;
      cmd_valid <= 1'b1;
      // Ready seen mid-cycle means the accept lands on the next rising edge
      do begin
         @(negedge clk);
      end while (!cmd_ready);
      @(posedge clk);
      cmd_valid <= 1'b0;
   endtask

   task automatic finish_run(input logic timed_out);
      $display("Errors: %0d mismatches, %0d other failures", mismatches,
               other_errs + int'(timed_out));
      if (mismatches == 0 && other_errs == 0 && !timed_out) begin
         $display("Finished with no errors");
      end else begin
         $display("Finished with errors");
      end
      $finish;
   endtask

   // Watchdog
   always @(posedge clk) begin
      cycles <= cycles + 1;
      if (cycles == TIMEOUT) begin
         $display("Timeout after %0d cycles with traffic still pending", TIMEOUT);
         finish_run(1'b1);
      end
   end

   //============================================================
   // Reset, configuration, command table
   //============================================================
   initial begin
      int i;
      void'($urandom(73279));
      resetn    = 1'b0;
      cfg       = '0;
      cmd_phase = 1'b0;
      cmd_valid = 1'b0;
      exp_row   = '0;
      stall_pct = '0;
      repeat (5) @(posedge clk);
      resetn <= 1'b1;
      // Frame bases then metadata bases, high word first
      for (i = 0; i < 4; i++) begin
         write_reg(REG_HFD00_ADDR_H + 2 * i, FD_BASE[i][63:32]);
         write_reg(REG_HFD00_ADDR_L + 2 * i, FD_BASE[i][31:0]);
      end
      for (i = 0; i < 2; i++) begin
         write_reg(REG_HMD0_ADDR_H + 2 * i, MD_BASE[i][63:32]);
         write_reg(REG_HMD0_ADDR_L + 2 * i, MD_BASE[i][31:0]);
      end
      write_reg(REG_HFD_BYTES_H, 32'd0);
      write_reg(REG_HFD_BYTES_L, 32'(FD_RING));
      write_reg(REG_HMD_BYTES_H, 32'd0);
      write_reg(REG_HMD_BYTES_L, 32'(MD_RING));
      write_reg(REG_FRAME_SIZE, 32'(FRAME_SIZE));
      // Out of range, should pulse cfg_err once
      write_reg(20, 32'h0bad_0bad);
      for (i = 0; i < NUM_ROWS; i++) begin
         send_cmd(rows[i]);
      end
      do begin
         @(negedge clk);
      end while (busy);
      repeat (5) @(posedge clk);
      finish_run(1'b0);
   end

endmodule

//--- sim/tb_checker.sv
// Reference model for requests and output streams; needs one exp_row per command, in command order
`timescale 1ns/1ns

module tb_checker #(
   parameter logic [3:0][63:0] FD_BASE    = '0,
   parameter logic [1:0][63:0] MD_BASE    = '0,
   parameter int               FRAME_SIZE = 1024,
   parameter int               FD_RING    = 1536,
   parameter int               MD_RING    = 384
) (
   input  logic               clk,
   input  logic               resetn,
   input  fetch_pkg::cfg_wr_t cfg,
   input  logic               cfg_err,
   input  logic               cmd_phase,
   input  logic               cmd_valid,
   input  logic               cmd_ready,
   input  logic [2:0]         exp_row,
   input  fetch_pkg::rd_req_t ar_req,
   input  logic               ar_valid,
   input  logic               ar_ready,
   input  fetch_pkg::beat_t   md_data,
   input  logic               md_valid,
   input  logic               md_ready,
   input  fetch_pkg::beat_t   fd_data,
   input  logic               fd_valid,
   input  logic               fd_ready,
   output int                 mismatches,
   output int                 other_errs,
   output logic               busy
);
   import fetch_pkg::*;

   // Expected traffic, oldest first
   rd_req_t req_q [$];
   beat_t   md_q [$];
   beat_t   fd_q [$];
   logic    bad_wr_q;

   task automatic compare(input string name, input logic [63:0] exp, input logic [63:0] act);
      if (exp !== act) begin
         mismatches++;
         $display("Mismatch at %0t: %s expected %h got %h", $time, name, exp, act);
      end
   endtask

   //============================================================
   // Expected requests and words for one command
   //============================================================
   task automatic expect_cmd(input logic p, input int row);
      logic [63:0] addr;
      int          s;
      int          b;
      int          k;
      // Ring offset is the command count times the step, folded into the ring
      addr = MD_BASE[p] + 64'((row * MD_BYTES) % MD_RING);
      req_q.push_back('{addr: addr, len: 8'(MD_BEATS - 1)});
      for (k = 0; k < MD_BEATS; k++) begin
         md_q.push_back(addr + 64'(k * BUS_BYTES));
      end
      // Half a frame per semiphase, split into fixed bursts
      for (s = 0; s < 2; s++) begin
         for (b = 0; b < FRAME_SIZE / (2 * BURST_BYTES); b++) begin
            addr = FD_BASE[2 * int'(p) + s] + 64'((row * (FRAME_SIZE / 2)) % FD_RING)
                 + 64'(b * BURST_BYTES);
            req_q.push_back('{addr: addr, len: 8'(BURST_BEATS - 1)});
            for (k = 0; k < BURST_BEATS; k++) begin
               fd_q.push_back(addr + 64'(k * BUS_BYTES));
            end
         end
      end
   endtask

   always @(posedge clk) begin
      rd_req_t r;
      beat_t   w;
      if (!resetn) begin
         bad_wr_q <= 1'b0;
         busy     <= 1'b0;
      end else begin
         // Error flag follows a write outside 1 to 17 by one cycle
         compare("cfg_err", 64'(bad_wr_q), 64'(cfg_err));
         bad_wr_q <= cfg.wr && (cfg.idx < 5'd1 || cfg.idx > 5'd17);
         // Requests run back to back from the accept, commands reopen after the last one
         compare("cmd_ready", 64'(req_q.size() == 0), 64'(cmd_ready));
         compare("ar_valid", 64'(req_q.size() != 0), 64'(ar_valid));
         if (cmd_valid && cmd_ready) begin
            expect_cmd(cmd_phase, int'(exp_row));
         end
         if (ar_valid && ar_ready) begin
            if (req_q.size() == 0) begin
               other_errs++;
               $display("Read request at %0t with no command to explain it", $time);
            end else begin
               r = req_q.pop_front();
               compare("ar_req.addr", r.addr, ar_req.addr);
               compare("ar_req.len", 64'(r.len), 64'(ar_req.len));
            end
         end
         if (md_valid && md_ready) begin
            if (md_q.size() == 0) begin
               other_errs++;
               $display("Metadata word at %0t with no command to explain it", $time);
            end else begin
               w = md_q.pop_front();
               compare("md_data", w, md_data);
            end
         end
         if (fd_valid && fd_ready) begin
            if (fd_q.size() == 0) begin
               other_errs++;
               $display("Frame word at %0t with no command to explain it", $time);
            end else begin
               w = fd_q.pop_front();
               compare("fd_data", w, fd_data);
            end
         end
         busy <= (req_q.size() + md_q.size() + fd_q.size()) != 0;
      end
   end

endmodule

//--- verilog/data_fetch.sv
// Fetch engine top; read data must come back in request order, config is written before commands
`timescale 1ns/1ns

module data_fetch (
   input  logic               clk,
   input  logic               resetn,
   // Register write port
   input  fetch_pkg::cfg_wr_t cfg,
   output logic               cfg_err,
   // Phase command
   input  logic               cmd_phase,
   input  logic               cmd_valid,
   output logic               cmd_ready,
   // Read request channel
   output fetch_pkg::rd_req_t ar_req,
   output logic               ar_valid,
   input  logic               ar_ready,
   // Read data
   input  fetch_pkg::beat_t   r_data,
   input  logic               r_valid,
   output logic               r_ready,
   // Metadata stream
   output fetch_pkg::beat_t   md_data,
   output logic               md_valid,
   input  logic               md_ready,
   // Frame-data stream
   output fetch_pkg::beat_t   fd_data,
   output logic               fd_valid,
   input  logic               fd_ready
);
   import fetch_pkg::*;

   fetch_cfg_t  fetch_cfg;
   ptr_inc_t    inc;
   logic        phase;
   logic [63:0] md_ptr;
   logic [63:0] fd_ptr0;
   logic [63:0] fd_ptr1;
   logic        md_wr_valid;
   logic        fd_wr_valid;
   logic        md_room;
   logic        fd_room;

   //============================================================
   // Config and request side
   //============================================================
   fetch_regs regs_inst (
      .clk     (clk),
      .resetn  (resetn),
      .cfg     (cfg),
      .cfg_out (fetch_cfg),
      .cfg_err (cfg_err)
   );

   ring_offsets offs_inst (
      .clk     (clk),
      .resetn  (resetn),
      .cfg     (fetch_cfg),
      .phase   (phase),
      .inc     (inc),
      .md_ptr  (md_ptr),
      .fd_ptr0 (fd_ptr0),
      .fd_ptr1 (fd_ptr1)
   );

   fetch_fsm fsm_inst (
      .clk       (clk),
      .resetn    (resetn),
      .cfg       (fetch_cfg),
      .cmd_phase (cmd_phase),
      .cmd_valid (cmd_valid),
      .cmd_ready (cmd_ready),
      .md_ptr    (md_ptr),
      .fd_ptr0   (fd_ptr0),
      .fd_ptr1   (fd_ptr1),
      .phase     (phase),
      .inc       (inc),
      .ar_req    (ar_req),
      .ar_valid  (ar_valid),
      .ar_ready  (ar_ready)
   );

   //============================================================
   // Return data side
   //============================================================
   beat_router router_inst (
      .clk         (clk),
      .resetn      (resetn),
      .cfg         (fetch_cfg),
      .r_valid     (r_valid),
      .r_ready     (r_ready),
      .md_wr_valid (md_wr_valid),
      .fd_wr_valid (fd_wr_valid),
      .md_room     (md_room),
      .fd_room     (fd_room)
   );

   // Both FIFOs see the raw read data, the router picks who writes
   stream_fifo #(.DEPTH(MD_FIFO_DEPTH)) md_fifo (
      .clk       (clk),
      .resetn    (resetn),
      .in_data   (r_data),
      .in_valid  (md_wr_valid),
      .in_ready  (md_room),
      .out_data  (md_data),
      .out_valid (md_valid),
      .out_ready (md_ready)
   );

   stream_fifo #(.DEPTH(FD_FIFO_DEPTH)) fd_fifo (
      .clk       (clk),
      .resetn    (resetn),
      .in_data   (r_data),
      .in_valid  (fd_wr_valid),
      .in_ready  (fd_room),
      .out_data  (fd_data),
      .out_valid (fd_valid),
      .out_ready (fd_ready)
   );

endmodule

//--- verilog/stream_fifo.sv
// Single-clock valid/ready FIFO; DEPTH must be a power of two
`timescale 1ns/1ns

module stream_fifo #(
   parameter int DEPTH = 16
) (
   input  logic             clk,
   input  logic             resetn,
   input  fetch_pkg::beat_t in_data,
   input  logic             in_valid,
   output logic             in_ready,
   output fetch_pkg::beat_t out_data,
   output logic             out_valid,
   input  logic             out_ready
);
   localparam int AW = $clog2(DEPTH);
   localparam int CW = $clog2(DEPTH + 1);

   fetch_pkg::beat_t mem [DEPTH];
   logic [AW-1:0]    wr_ptr;
   logic [AW-1:0]    rd_ptr;
   logic [CW-1:0]    count;
   logic             do_wr;
   logic             do_rd;

   assign in_ready  = (count != CW'(DEPTH));
   assign out_valid = (count != '0);
   assign out_data  = mem[rd_ptr];

   assign do_wr = in_valid && in_ready;
   assign do_rd = out_valid && out_ready;

   // Storage
   always_ff @(posedge clk) begin
      if (do_wr) begin
         mem[wr_ptr] <= in_data;
      end
   end

   //============================================================
   // Pointers and fill level
   //============================================================
   always_ff @(posedge clk) begin
      if (!resetn) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
      end else begin
         // Pointers wrap on their own width
         if (do_wr) begin
            wr_ptr <= wr_ptr + 1'b1;
         end
         if (do_rd) begin
            rd_ptr <= rd_ptr + 1'b1;
         end
         case ({do_wr, do_rd})
            2'b10:   count <= count + 1'b1;
            2'b01:   count <= count - 1'b1;
            default: count <= count;
         endcase
      end
   end

   // Upstream qualifies its write strobe with room, so nothing arrives when full
   a_no_full_wr: assert property (@(posedge clk) disable iff (!resetn)
      !in_ready |-> !in_valid);

endmodule

//--- verilog/beat_router.sv
// Beat steering; assumes read data returns in request order, one whole phase at a time
`timescale 1ns/1ns

module beat_router (
   input  logic                  clk,
   input  logic                  resetn,
   input  fetch_pkg::fetch_cfg_t cfg,
   input  logic                  r_valid,
   output logic                  r_ready,
   output logic                  md_wr_valid,
   output logic                  fd_wr_valid,
   input  logic                  md_room,
   input  logic                  fd_room
);
   import fetch_pkg::*;

   // 1-based beat number inside the current phase
   logic [31:0] beat_cnt;
   logic [31:0] beats_per_phase;
   logic        beat_ok;
   logic        is_md;

   // Metadata record then the whole frame
   assign beats_per_phase = 32'(MD_BEATS) + cfg.frame_size / BUS_BYTES;

   // Both FIFOs need room, metadata cannot overflow
   assign r_ready = md_room && fd_room;
   assign beat_ok = r_valid && r_ready;
   assign is_md   = (beat_cnt <= MD_BEATS);

   assign md_wr_valid = beat_ok && is_md;
   assign fd_wr_valid = beat_ok && !is_md;

   //============================================================
   // Beat counter, wraps after one phase
   //============================================================
   always_ff @(posedge clk) begin
      if (!resetn) begin
         beat_cnt <= 32'd1;
      end else if (beat_ok) begin
         beat_cnt <= (beat_cnt == beats_per_phase) ? 32'd1 : beat_cnt + 32'd1;
      end
   end

endmodule

//--- verilog/fetch_fsm.sv
// Command FSM; frame size must be a nonzero multiple of 512 so each semiphase is whole bursts
`timescale 1ns/1ns

module fetch_fsm (
   input  logic                  clk,
   input  logic                  resetn,
   input  fetch_pkg::fetch_cfg_t cfg,
   input  logic                  cmd_phase,
   input  logic                  cmd_valid,
   output logic                  cmd_ready,
   input  logic [63:0]           md_ptr,
   input  logic [63:0]           fd_ptr0,
   input  logic [63:0]           fd_ptr1,
   output logic                  phase,
   output fetch_pkg::ptr_inc_t   inc,
   output fetch_pkg::rd_req_t    ar_req,
   output logic                  ar_valid,
   input  logic                  ar_ready
);
   import fetch_pkg::*;

   typedef enum logic [1:0] {
      S_WAIT,
      S_MD,
      S_FD0,
      S_FD1
   } state_t;

   state_t      state;
   logic        phase_q;
   logic [31:0] burst_cnt;
   logic [31:0] bursts_per_semi;
   logic        last_burst;

   // Two semiphases per frame, fixed burst size
   assign bursts_per_semi = cfg.frame_size / (2 * BURST_BYTES);
   assign last_burst      = (burst_cnt >= bursts_per_semi);

   assign cmd_ready = (state == S_WAIT);
   assign ar_valid  = (state != S_WAIT);

   // Command phase while idle so the metadata pointer is ready at accept
   assign phase = (state == S_WAIT) ? cmd_phase : phase_q;

   //============================================================
   // Request sequencing
   //============================================================
   always_ff @(posedge clk) begin
      // Increment strobes last a single cycle
      inc <= INC_NONE;
      if (!resetn) begin
         state     <= S_WAIT;
         burst_cnt <= '0;
      end else begin
         case (state)
            // Latch phase, present the metadata request
            S_WAIT: if (cmd_valid) begin
               phase_q     <= cmd_phase;
               ar_req.addr <= md_ptr;
               ar_req.len  <= 8'(MD_BEATS - 1);
               inc         <= INC_MD;
               state       <= S_MD;
            end
            // Metadata taken, first burst of semiphase 0
            S_MD: if (ar_ready) begin
               burst_cnt   <= 32'd1;
               ar_req.addr <= fd_ptr0;
               ar_req.len  <= 8'(BURST_BEATS - 1);
               inc         <= INC_FD0;
               state       <= S_FD0;
            end
            S_FD0: if (ar_ready) begin
               if (!last_burst) begin
                  burst_cnt   <= burst_cnt + 32'd1;
                  ar_req.addr <= ar_req.addr + 64'(BURST_BYTES);
               end else begin
                  // Move to semiphase 1
                  burst_cnt   <= 32'd1;
                  ar_req.addr <= fd_ptr1;
                  inc         <= INC_FD1;
                  state       <= S_FD1;
               end
            end
            S_FD1: if (ar_ready) begin
               if (!last_burst) begin
                  burst_cnt   <= burst_cnt + 32'd1;
                  ar_req.addr <= ar_req.addr + 64'(BURST_BYTES);
               end else begin
                  state <= S_WAIT;
               end
            end
            default: state <= S_WAIT;
         endcase
      end
   end

   // Request stays put until the bus takes it
   a_ar_hold: assert property (@(posedge clk) disable iff (!resetn)
      ar_valid && !ar_ready |=> ar_valid && $stable(ar_req));

   // Whole bursts only, at least one per semiphase
   a_frame_size: assert property (@(posedge clk) disable iff (!resetn)
      cmd_valid && cmd_ready |-> bursts_per_semi != 0 && cfg.frame_size[8:0] == 9'd0);

endmodule

//--- verilog/ring_offsets.sv
// Ring offsets per phase; an offset wraps to zero once it reaches the ring size, sizes nonzero
`timescale 1ns/1ns

module ring_offsets (
   input  logic                  clk,
   input  logic                  resetn,
   input  fetch_pkg::fetch_cfg_t cfg,
   input  logic                  phase,
   input  fetch_pkg::ptr_inc_t   inc,
   output logic [63:0]           md_ptr,
   output logic [63:0]           fd_ptr0,
   output logic [63:0]           fd_ptr1
);
   import fetch_pkg::*;

   // Offsets into host rings, [phase] and [phase][semiphase]
   logic [1:0][63:0]      md_offs;
   logic [1:0][1:0][63:0] fd_offs;
   logic [63:0]           semi_bytes;
   logic [63:0]           md_next;
   logic [63:0]           fd0_next;
   logic [63:0]           fd1_next;

   // Half a frame per semiphase
   assign semi_bytes = {33'd0, cfg.frame_size[31:1]};

   assign md_next  = md_offs[phase] + 64'(MD_BYTES);
   assign fd0_next = fd_offs[phase][0] + semi_bytes;
   assign fd1_next = fd_offs[phase][1] + semi_bytes;

   //============================================================
   // Advance the selected offset on an increment pulse
   //============================================================
   always_ff @(posedge clk) begin
      if (!resetn) begin
         md_offs <= '0;
         fd_offs <= '0;
      end else begin
         case (inc)
            INC_MD:  md_offs[phase]    <= (md_next  < cfg.md_bytes) ? md_next  : '0;
            INC_FD0: fd_offs[phase][0] <= (fd0_next < cfg.fd_bytes) ? fd0_next : '0;
            INC_FD1: fd_offs[phase][1] <= (fd1_next < cfg.fd_bytes) ? fd1_next : '0;
            default: begin
            end
         endcase
      end
   end

   // Host pointers, base plus offset for the phase in use
   assign md_ptr  = cfg.md_base[phase] + md_offs[phase];
   assign fd_ptr0 = cfg.fd_base[phase][0] + fd_offs[phase][0];
   assign fd_ptr1 = cfg.fd_base[phase][1] + fd_offs[phase][1];

endmodule

//--- verilog/fetch_regs.sv
// Config registers, write only; any index outside 1 to 17 is dropped and flagged on cfg_err
`timescale 1ns/1ns

module fetch_regs (
   input  logic                  clk,
   input  logic                  resetn,
   input  fetch_pkg::cfg_wr_t    cfg,
   output fetch_pkg::fetch_cfg_t cfg_out,
   output logic                  cfg_err
);
   import fetch_pkg::*;

   logic idx_ok;

   // Valid register window
   assign idx_ok = (cfg.idx >= REG_HFD00_ADDR_H) && (cfg.idx <= REG_FRAME_SIZE);

   //============================================================
   // Write decode, each 64-bit field split into high and low words
   //============================================================
   always_ff @(posedge clk) begin
      if (!resetn) begin
         cfg_out <= '0;
         cfg_err <= 1'b0;
      end else begin
         // One-cycle pulse per bad write
         cfg_err <= cfg.wr && !idx_ok;
         if (cfg.wr) begin
            case (cfg.idx)
               REG_HFD00_ADDR_H: cfg_out.fd_base[0][0][63:32] <= cfg.data;
               REG_HFD00_ADDR_L: cfg_out.fd_base[0][0][31:0]  <= cfg.data;
               REG_HFD01_ADDR_H: cfg_out.fd_base[0][1][63:32] <= cfg.data;
               REG_HFD01_ADDR_L: cfg_out.fd_base[0][1][31:0]  <= cfg.data;
               REG_HFD10_ADDR_H: cfg_out.fd_base[1][0][63:32] <= cfg.data;
               REG_HFD10_ADDR_L: cfg_out.fd_base[1][0][31:0]  <= cfg.data;
               REG_HFD11_ADDR_H: cfg_out.fd_base[1][1][63:32] <= cfg.data;
               REG_HFD11_ADDR_L: cfg_out.fd_base[1][1][31:0]  <= cfg.data;
               // Metadata rings
               REG_HMD0_ADDR_H:  cfg_out.md_base[0][63:32]    <= cfg.data;
               REG_HMD0_ADDR_L:  cfg_out.md_base[0][31:0]     <= cfg.data;
               REG_HMD1_ADDR_H:  cfg_out.md_base[1][63:32]    <= cfg.data;
               REG_HMD1_ADDR_L:  cfg_out.md_base[1][31:0]     <= cfg.data;
               // Ring sizes
               REG_HFD_BYTES_H:  cfg_out.fd_bytes[63:32]      <= cfg.data;
               REG_HFD_BYTES_L:  cfg_out.fd_bytes[31:0]       <= cfg.data;
               REG_HMD_BYTES_H:  cfg_out.md_bytes[63:32]      <= cfg.data;
               REG_HMD_BYTES_L:  cfg_out.md_bytes[31:0]       <= cfg.data;
               REG_FRAME_SIZE:   cfg_out.frame_size           <= cfg.data;
               default: begin
               end
            endcase
         end
      end
   end

   // Host never issues two bad writes back to back, so the flag is a single pulse
   a_err_pulse: assert property (@(posedge clk) disable iff (!resetn)
      cfg_err |=> !cfg_err);

endmodule

//--- verilog/fetch_pkg.sv
// Shared sizes, register map and bus types; the design assumes a 64-bit read data bus
package fetch_pkg;

   //============================================================
   // Bus and transfer sizes
   //============================================================
   localparam int BUS_BITS      = 64;
   localparam int BUS_BYTES     = 8;
   // One metadata record per phase
   localparam int MD_BYTES      = 128;
   localparam int MD_BEATS      = 16;
   // Fixed frame-data burst
   localparam int BURST_BYTES   = 256;
   localparam int BURST_BEATS   = 32;
   localparam int MD_FIFO_DEPTH = 32;
   localparam int FD_FIFO_DEPTH = 64;

   //============================================================
   // Register map, indices kept from the host driver
   //============================================================
   localparam int REG_IDX_BITS     = 5;
   // Frame data, phase 0, semiphases 0 and 1
   localparam int REG_HFD00_ADDR_H = 1;
   localparam int REG_HFD00_ADDR_L = 2;
   localparam int REG_HFD01_ADDR_H = 3;
   localparam int REG_HFD01_ADDR_L = 4;
   // Frame data, phase 1, semiphases 0 and 1
   localparam int REG_HFD10_ADDR_H = 5;
   localparam int REG_HFD10_ADDR_L = 6;
   localparam int REG_HFD11_ADDR_H = 7;
   localparam int REG_HFD11_ADDR_L = 8;
   // Metadata bases, one per phase
   localparam int REG_HMD0_ADDR_H  = 9;
   localparam int REG_HMD0_ADDR_L  = 10;
   localparam int REG_HMD1_ADDR_H  = 11;
   localparam int REG_HMD1_ADDR_L  = 12;
   // Ring sizes in bytes
   localparam int REG_HFD_BYTES_H  = 13;
   localparam int REG_HFD_BYTES_L  = 14;
   localparam int REG_HMD_BYTES_H  = 15;
   localparam int REG_HMD_BYTES_L  = 16;
   // Bytes in a full frame, both semiphases
   localparam int REG_FRAME_SIZE   = 17;

   //============================================================
   // Shared types
   //============================================================
   typedef logic [BUS_BITS-1:0] beat_t;

   typedef struct packed {
      logic                    wr;
      logic [REG_IDX_BITS-1:0] idx;
      logic [31:0]             data;
   } cfg_wr_t;

   typedef struct packed {
      // Indexed [phase][semiphase]
      logic [1:0][1:0][63:0] fd_base;
      // Indexed [phase]
      logic [1:0][63:0]      md_base;
      logic [63:0]           fd_bytes;
      logic [63:0]           md_bytes;
      logic [31:0]           frame_size;
   } fetch_cfg_t;

   typedef struct packed {
      logic [63:0] addr;
      // Beats minus one
      logic [7:0]  len;
   } rd_req_t;

   typedef enum logic [1:0] {
      INC_NONE,
      INC_MD,
      INC_FD0,
      INC_FD1
   } ptr_inc_t;

endpackage
